/* hdl/knight_pkg.sv */
// Knight command processor package with opcodes, states, widths and tuning constants.
`default_nettype none

package knight_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command and sequencer encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    CAL     = 4'h2,                       // Start gyro calibration.
    MOV     = 4'h4,                       // Turn, then drive N squares.
    FANFARE = 4'h5,                       // Move with fanfare at the end.
    TOUR    = 4'h6                        // Kick off the tour logic.
  } op_t;

  typedef enum logic [2:0] {
    IDLE,                                 // Waiting for cmd_rdy.
    CALIBRATE,                            // Waiting for cal_done.
    MOVE,                                 // Turning toward desired heading.
    INCR,                                 // Ramping speed up over squares.
    DECR                                  // Ramping speed down to a stop.
  } state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath widths and types
  ////////////////////////////////////////////////////////////////////////////
  localparam int HEAD_W  = 12;            // Heading and error width.
  localparam int FRWRD_W = 10;            // Forward speed width.

  typedef logic signed [HEAD_W-1:0] heading_t;
  typedef logic [FRWRD_W-1:0]       frwrd_t;

  ////////////////////////////////////////////////////////////////////////////
  // Tuning constants
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [HEAD_W-1:0] ALIGN_THR = 12'h02C; // Aligned below this |error|.

  localparam frwrd_t INC_FAST = 10'h020;  // Ramp up step, fast sim.
  localparam frwrd_t INC_SLOW = 10'h003;  // Ramp up step, real robot.
  localparam frwrd_t DEC_FAST = 10'h040;  // Ramp down step, fast sim.
  localparam frwrd_t DEC_SLOW = 10'h006;  // Ramp down step, real robot.

  localparam heading_t NUDGE_FAST = 12'h1FF; // IR nudge, fast sim.
  localparam heading_t NUDGE_SLOW = 12'h05F; // IR nudge, real robot.

endpackage : knight_pkg

`default_nettype wire

/* hdl/move_ctrl_if.sv */
// Move control bundle between the command sequencer and its three datapath blocks.
`default_nettype none

interface move_ctrl_if (
  input logic clk
);

  logic move_cmd;                         // Latch heading and squares.
  logic clr_frwrd;                        // Clear speed register.
  logic inc_frwrd;                        // Ramp speed up.
  logic dec_frwrd;                        // Ramp speed down.
  logic aligned;                          // |error| below threshold.
  logic at_zero;                          // Speed register is zero.
  logic move_done;                        // Square target reached.

  modport seq (
    output move_cmd, clr_frwrd, inc_frwrd, dec_frwrd,
    input  aligned, at_zero, move_done
  );

  modport head  (input move_cmd, output aligned);
  modport ramp  (input clr_frwrd, inc_frwrd, dec_frwrd, output at_zero);
  modport count (input move_cmd, output move_done);

endinterface : move_ctrl_if

`default_nettype wire

/* hdl/cmd_sequencer.sv */
// Command sequencer FSM that dispatches calibration, tour and move commands.
`default_nettype none

module cmd_sequencer
  import knight_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_rdy,            // Command waiting.
  input  logic        cal_done,           // Gyro calibration finished.
  input  op_t         opcode,             // Held in cmd until send_resp.
  output logic        clr_cmd_rdy,        // Command consumed.
  output logic        send_resp,          // Command finished.
  output logic        strt_cal,           // Start gyro calibration.
  output logic        tour_go,            // Start tour logic.
  output logic        fanfare_go,         // Play the charge tune.
  output logic        moving,             // Robot in motion.
  move_ctrl_if.seq    ctl
);

  state_t state;                          // Current state.
  state_t nxt_state;                      // Next state.

  ////////////////////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;                      // Come up waiting for a command.
    else
      state <= nxt_state;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transition and output logic
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state     = state;                // Hold by default.
    clr_cmd_rdy   = 1'b0;
    send_resp     = 1'b0;
    strt_cal      = 1'b0;
    tour_go       = 1'b0;
    fanfare_go    = 1'b0;
    moving        = 1'b0;
    ctl.move_cmd  = 1'b0;
    ctl.clr_frwrd = 1'b0;
    ctl.inc_frwrd = 1'b0;
    ctl.dec_frwrd = 1'b0;

    case (state)
      IDLE: begin
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;             // Every opcode is consumed.
          case (opcode)
            TOUR: tour_go = 1'b1;         // No response for tour.
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            MOV, FANFARE: begin
              ctl.move_cmd = 1'b1;        // Latch heading and squares.
              nxt_state    = MOVE;
            end
            default: ;                    // Unknown opcode is dropped.
          endcase
        end
      end

      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;
          nxt_state = IDLE;
        end
      end

      MOVE: begin
        moving = 1'b1;                    // Turning counts as moving.
        if (ctl.aligned) begin
          ctl.clr_frwrd = 1'b1;           // Start the ramp from rest.
          nxt_state     = INCR;
        end
      end

      INCR: begin
        moving        = 1'b1;
        ctl.inc_frwrd = 1'b1;
        if (ctl.move_done) begin
          fanfare_go = (opcode == FANFARE); // Tune on the last square.
          nxt_state  = DECR;
        end
      end

      DECR: begin
        ctl.dec_frwrd = 1'b1;
        if (ctl.at_zero) begin
          send_resp = 1'b1;               // Stopped, so the move is done.
          nxt_state = IDLE;
        end else begin
          moving = 1'b1;
        end
      end

      default: nxt_state = IDLE;          // Recover from unused codes.
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  a_ramp_onehot : assert property (
    @(posedge clk) disable iff (!rst_n) !(ctl.inc_frwrd && ctl.dec_frwrd)
  ) else $error("inc_frwrd and dec_frwrd both high");

  a_no_resp_idle : assert property (
    @(posedge clk) disable iff (!rst_n) (state == IDLE) |-> !send_resp
  ) else $error("send_resp raised in IDLE");

endmodule : cmd_sequencer

`default_nettype wire

/* hdl/heading_error.sv */
// Heading error block that latches the desired heading and forms the nudged error.
`default_nettype none

module heading_error
  import knight_pkg::*;
#(
  parameter bit FAST_SIM = 1'b1           // Pick the large nudge for sim.
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [7:0]  cmd_heading,        // cmd[11:4].
  input  heading_t    heading,            // From the gyro.
  input  logic        lftIR,              // Drifting left, nudge positive.
  input  logic        rghtIR,             // Drifting right, nudge negative.
  output heading_t    error,              // To the PID.
  move_ctrl_if.head   ctl
);

  localparam heading_t NUDGE = FAST_SIM ? NUDGE_FAST : NUDGE_SLOW;

  heading_t          desired_hdg;         // Latched target heading.
  heading_t          nudge;               // IR correction term.
  logic [HEAD_W-1:0] err_abs;             // Magnitude of error.

  ////////////////////////////////////////////////////////////////////////////
  // Desired heading
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      desired_hdg <= '0;                  // North until the first move.
    else if (ctl.move_cmd) begin
      if (cmd_heading == 8'h00)
        desired_hdg <= '0;                // Exact north.
      else
        desired_hdg <= {cmd_heading, 4'hF}; // Pad the low nibble.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error term
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    if (lftIR)
      nudge = NUDGE;                      // Left wins when both see a line.
    else if (rghtIR)
      nudge = -NUDGE;
    else
      nudge = '0;
  end

  assign error = heading - desired_hdg + nudge; // Wraps modulo 2^12.

  assign err_abs = error[HEAD_W-1] ? -error : error;

  assign ctl.aligned = (err_abs < ALIGN_THR); // Close enough to drive.

endmodule : heading_error

`default_nettype wire

/* hdl/speed_ramp.sv */
// Forward speed register that ramps up and down on each heading update.
`default_nettype none

module speed_ramp
  import knight_pkg::*;
#(
  parameter bit FAST_SIM = 1'b1           // Large steps for sim.
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        heading_rdy,        // One pulse per gyro reading.
  output frwrd_t      frwrd,              // Forward speed.
  move_ctrl_if.ramp   ctl
);

  localparam frwrd_t INC_STEP = FAST_SIM ? INC_FAST : INC_SLOW;
  localparam frwrd_t DEC_STEP = FAST_SIM ? DEC_FAST : DEC_SLOW;

  logic max_spd;                          // Top two bits set.

  assign max_spd     = &frwrd[FRWRD_W-1 -: 2];
  assign ctl.at_zero = (frwrd == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Speed register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      frwrd <= '0;
    else if (ctl.clr_frwrd)
      frwrd <= '0;                        // Start of the straight run.
    else if (heading_rdy) begin
      if (ctl.inc_frwrd) begin
        if (!max_spd)
          frwrd <= frwrd + INC_STEP;      // Hold once at top speed.
      end else if (ctl.dec_frwrd) begin
        if (frwrd > DEC_STEP)
          frwrd <= frwrd - DEC_STEP;
        else
          frwrd <= '0;                    // Clamp, never wrap.
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  // Speed moves only on gyro updates, apart from an explicit clear.
  a_step_on_rdy : assert property (
    @(posedge clk) disable iff (!rst_n)
      (!heading_rdy && !ctl.clr_frwrd) |=> $stable(frwrd)
  ) else $error("frwrd changed without heading_rdy");

endmodule : speed_ramp

`default_nettype wire

/* hdl/square_counter.sv */
// Square counter that counts centre IR line crossings against the commanded squares.
`default_nettype none

module square_counter (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cntrIR,             // Centre IR, high over a line.
  input  logic [3:0]  squares,            // cmd[3:0].
  move_ctrl_if.count  ctl
);

  logic       cntrIR_q;                   // Last cntrIR sample.
  logic       ir_rise;                    // Rising edge of cntrIR.
  logic [3:0] square_cnt;                 // Latched target squares.
  logic [4:0] pulse_cnt;                  // Lines seen this move.

  ////////////////////////////////////////////////////////////////////////////
  // Edge detect
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cntrIR_q <= 1'b0;
    else
      cntrIR_q <= cntrIR;
  end

  assign ir_rise = cntrIR & ~cntrIR_q;

  ////////////////////////////////////////////////////////////////////////////
  // Target and count
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      square_cnt <= '0;
      pulse_cnt  <= '0;
    end else if (ctl.move_cmd) begin
      square_cnt <= squares;              // New target per move.
      pulse_cnt  <= '0;                   // Restart the line count.
    end else if (ir_rise) begin
      pulse_cnt  <= pulse_cnt + 5'd1;
    end
  end

  // Two lines per square, one on each edge of the tape.
  assign ctl.move_done = (pulse_cnt == {square_cnt, 1'b0});

endmodule : square_counter

`default_nettype wire

/* hdl/cmd_proc.sv */
// Knight command processor top that joins the sequencer and the move datapath.
`default_nettype none

module cmd_proc
  import knight_pkg::*;
#(
  parameter bit FAST_SIM = 1'b1           // Shorter ramps and larger nudge.
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd,                // Opcode, heading, squares.
  input  logic        cmd_rdy,            // Command valid.
  output logic        clr_cmd_rdy,        // Command consumed.
  output logic        send_resp,          // Command finished.
  output logic        strt_cal,           // Start gyro calibration.
  input  logic        cal_done,           // Gyro calibration done.
  input  heading_t    heading,            // Gyro heading.
  input  logic        heading_rdy,        // New heading this cycle.
  input  logic        lftIR,              // Left IR sensor.
  input  logic        cntrIR,             // Centre IR sensor.
  input  logic        rghtIR,             // Right IR sensor.
  output heading_t    error,              // Heading error to PID.
  output frwrd_t      frwrd,              // Forward speed to PID.
  output logic        moving,             // Robot in motion.
  output logic        tour_go,            // Start tour logic.
  output logic        fanfare_go          // Play the charge tune.
);

  op_t opcode;                            // cmd[15:12].

  assign opcode = op_t'(cmd[15:12]);

  move_ctrl_if u_ctl (.clk(clk));

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer and datapath
  ////////////////////////////////////////////////////////////////////////////
  cmd_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_rdy     (cmd_rdy),
    .cal_done    (cal_done),
    .opcode      (opcode),
    .clr_cmd_rdy (clr_cmd_rdy),
    .send_resp   (send_resp),
    .strt_cal    (strt_cal),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving),
    .ctl         (u_ctl.seq)
  );

  heading_error #(.FAST_SIM(FAST_SIM)) u_head (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_heading (cmd[11:4]),
    .heading     (heading),
    .lftIR       (lftIR),
    .rghtIR      (rghtIR),
    .error       (error),
    .ctl         (u_ctl.head)
  );

  speed_ramp #(.FAST_SIM(FAST_SIM)) u_ramp (
    .clk         (clk),
    .rst_n       (rst_n),
    .heading_rdy (heading_rdy),
    .frwrd       (frwrd),
    .ctl         (u_ctl.ramp)
  );

  square_counter u_count (
    .clk         (clk),
    .rst_n       (rst_n),
    .cntrIR      (cntrIR),
    .squares     (cmd[3:0]),
    .ctl         (u_ctl.count)
  );

endmodule : cmd_proc

`default_nettype wire

/* tests/knight_model.sv */
// Reference model of the knight command processor that predicts strobes, error and speed.
`default_nettype none

module knight_model
  import knight_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd,                // Same command the DUT sees.
  input  logic        cmd_rdy,
  input  logic        cal_done,
  input  heading_t    heading,
  input  logic        heading_rdy,
  input  logic        lftIR,
  input  logic        cntrIR,
  input  logic        rghtIR,
  output heading_t    exp_error,          // Predicted heading error.
  output frwrd_t      exp_frwrd,          // Predicted forward speed.
  output heading_t    exp_desired,        // Target heading of the current move.
  output logic        exp_accept,         // Predicted clr_cmd_rdy.
  output logic        exp_tour_go,
  output logic        exp_strt_cal,
  output logic        exp_resp,
  output logic        exp_fanfare,
  output logic        exp_moving,
  output logic        in_cal,             // Waiting on the gyro.
  output logic        in_turn,            // Turning toward the target.
  output logic        in_up               // Driving over the squares.
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [2:0]  P_IDLE      = 3'd0;
  localparam logic [2:0]  P_CAL       = 3'd1;
  localparam logic [2:0]  P_TURN      = 3'd2;
  localparam logic [2:0]  P_UP        = 3'd3;
  localparam logic [2:0]  P_DOWN      = 3'd4;
  localparam logic [11:0] NUDGE_MAG   = 12'h1FF; // Fast sim IR nudge.
  localparam logic [11:0] ALIGN_LIMIT = 12'd44;
  localparam logic [9:0]  RAMP_UP     = 10'd32;
  localparam logic [9:0]  RAMP_DOWN   = 10'd64;
  localparam logic [9:0]  TOP_SPEED   = 10'h300; // Both top bits set.

  logic [2:0]  phase;                     // Model phase of the command.
  logic [3:0]  opc;                       // cmd[15:12].
  logic [3:0]  sq_target;                 // Squares of this move.
  logic [4:0]  edges;                     // Centre IR rises since accept.
  logic        ir_prev;                   // Last centre IR sample.
  logic [11:0] nudge_val;
  logic [11:0] err_mag;
  logic        aligned;
  logic        target_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Predicted combinational outputs
  ////////////////////////////////////////////////////////////////////////////
  assign opc        = cmd[15:12];
  assign nudge_val  = lftIR ? NUDGE_MAG : (rghtIR ? (12'd0 - NUDGE_MAG) : 12'd0);
  assign exp_error  = heading - exp_desired + nudge_val; // Modulo 4096.
  assign err_mag    = exp_error[11] ? (12'd0 - exp_error) : exp_error;
  assign aligned    = (err_mag < ALIGN_LIMIT);
  assign target_hit = (edges == 5'(sq_target) * 5'd2); // Two lines a square.

  assign exp_accept   = (phase == P_IDLE) && cmd_rdy;
  assign exp_tour_go  = exp_accept && (opc == 4'h6);
  assign exp_strt_cal = exp_accept && (opc == 4'h2);
  assign exp_resp     = ((phase == P_CAL) && cal_done) ||
                        ((phase == P_DOWN) && (exp_frwrd == '0));
  assign exp_fanfare  = (phase == P_UP) && target_hit && (opc == 4'h5);
  assign exp_moving   = (phase == P_TURN) || (phase == P_UP) ||
                        ((phase == P_DOWN) && (exp_frwrd != '0));
  assign in_cal       = (phase == P_CAL);
  assign in_turn      = (phase == P_TURN);
  assign in_up        = (phase == P_UP);

  ////////////////////////////////////////////////////////////////////////////
  // Model state
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      phase       <= P_IDLE;
      exp_desired <= '0;
      exp_frwrd   <= '0;
      sq_target   <= '0;
      edges       <= '0;
      ir_prev     <= 1'b0;
    end else begin
      ir_prev <= cntrIR;
      if (cntrIR && !ir_prev)
        edges <= edges + 5'd1;            // Counted in every phase.
      case (phase)
        P_IDLE: begin
          if (exp_accept && (opc == 4'h2))
            phase <= P_CAL;
          else if (exp_accept && ((opc == 4'h4) || (opc == 4'h5))) begin
            phase       <= P_TURN;
            exp_desired <= (cmd[11:4] == 8'h00) ? 12'h000 : {cmd[11:4], 4'hF};
            sq_target   <= cmd[3:0];
            edges       <= '0;            // Overrides a rise in this cycle.
          end
        end
        P_CAL: begin
          if (cal_done)
            phase <= P_IDLE;
        end
        P_TURN: begin
          if (aligned) begin
            phase     <= P_UP;
            exp_frwrd <= '0;              // Straight run starts from rest.
          end
        end
        P_UP: begin
          if (heading_rdy && (exp_frwrd < TOP_SPEED))
            exp_frwrd <= exp_frwrd + RAMP_UP;
          if (target_hit)
            phase <= P_DOWN;
        end
        P_DOWN: begin
          if (exp_frwrd == '0)
            phase <= P_IDLE;
          else if (heading_rdy)
            exp_frwrd <= (exp_frwrd >= RAMP_DOWN) ? exp_frwrd - RAMP_DOWN : '0;
        end
        default: phase <= P_IDLE;
      endcase
    end
  end

endmodule : knight_model

`default_nettype wire

/* tests/cmd_proc_tb.sv */
// Testbench for the knight command processor with random commands against a reference model.
`default_nettype none

module cmd_proc_tb
  import knight_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CMDS = 40;
  localparam int TIMEOUT  = 2000;         // Cycles per wait.

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd;
  logic        cmd_rdy;
  logic        cal_done;
  heading_t    heading;
  logic        heading_rdy;
  logic        lftIR;
  logic        cntrIR;
  logic        rghtIR;
  logic        clr_cmd_rdy;
  logic        send_resp;
  logic        strt_cal;
  logic        tour_go;
  logic        fanfare_go;
  logic        moving;
  heading_t    error;
  frwrd_t      frwrd;

  heading_t    exp_error;
  frwrd_t      exp_frwrd;
  heading_t    exp_desired;
  logic        exp_accept;
  logic        exp_tour_go;
  logic        exp_strt_cal;
  logic        exp_resp;
  logic        exp_fanfare;
  logic        exp_moving;
  logic        in_cal;
  logic        in_turn;
  logic        in_up;

  int accept_seen;                        // Strobe counts for one command.
  int resp_seen;
  int fanfare_seen;
  int tour_seen;
  int rdy_wait;                           // Cycles to next heading_rdy.
  int ir_wait;                            // Cycles to next cntrIR toggle.
  int cal_wait;                           // Cycles until cal_done.
  int turn_cycles;                        // Cycles spent turning.

  cmd_proc #(.FAST_SIM(1'b1)) UUT (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_rdy(cmd_rdy),
    .clr_cmd_rdy(clr_cmd_rdy), .send_resp(send_resp), .strt_cal(strt_cal),
    .cal_done(cal_done), .heading(heading), .heading_rdy(heading_rdy),
    .lftIR(lftIR), .cntrIR(cntrIR), .rghtIR(rghtIR), .error(error),
    .frwrd(frwrd), .moving(moving), .tour_go(tour_go), .fanfare_go(fanfare_go)
  );

  knight_model model (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_rdy(cmd_rdy), .cal_done(cal_done),
    .heading(heading), .heading_rdy(heading_rdy), .lftIR(lftIR), .cntrIR(cntrIR),
    .rghtIR(rghtIR), .exp_error(exp_error), .exp_frwrd(exp_frwrd),
    .exp_desired(exp_desired), .exp_accept(exp_accept), .exp_tour_go(exp_tour_go),
    .exp_strt_cal(exp_strt_cal), .exp_resp(exp_resp), .exp_fanfare(exp_fanfare),
    .exp_moving(exp_moving), .in_cal(in_cal), .in_turn(in_turn), .in_up(in_up)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;               // 40 ns period.
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Robot side responders, driven 5 ns after the edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic drive_responders();
    heading_rdy = 1'b0;
    if (rdy_wait == 0) begin
      heading_rdy = 1'b1;                 // New gyro reading.
      rdy_wait    = 1 + $urandom % 4;
    end else
      rdy_wait--;
    lftIR  = (($urandom % 8) == 0);       // Mostly clear of the tape.
    rghtIR = (($urandom % 8) == 0);
    if (in_turn) begin
      turn_cycles++;
      if (turn_cycles < 3)
        heading = heading_t'($urandom);   // Still swinging around.
      else
        heading = exp_desired + heading_t'(($urandom % 32) - 16);
    end else begin
      turn_cycles = 0;
      heading     = heading_t'($urandom);
    end
    if (in_up) begin
      if (ir_wait == 0) begin
        cntrIR  = ~cntrIR;                // Crossing a line edge.
        ir_wait = 4 + $urandom % 8;       // Long runs reach top speed.
      end else
        ir_wait--;
    end else begin
      cntrIR  = 1'b0;
      ir_wait = 4 + $urandom % 8;
    end
    cal_done = 1'b0;
    if (in_cal) begin
      if (cal_wait == 0)
        cal_done = 1'b1;                  // One cycle pulse.
      else
        cal_wait--;
    end else
      cal_wait = $urandom % 8;
  endtask

  task automatic step();
    @(posedge clk);
    #5;
    drive_responders();
  endtask

  task automatic wait_for_event(input bit want_resp, input string what);
    int waited;
    waited = 0;
    while ((want_resp ? resp_seen : accept_seen) == 0) begin
      step();
      waited++;
      if (waited > TIMEOUT)
        fail_now($sformatf("Timeout: no %s within %0d cycles", what, TIMEOUT));
    end
  endtask

  task automatic run_command(input op_t op, input logic [7:0] hdg, input logic [3:0] sq);
    accept_seen  = 0;
    resp_seen    = 0;
    fanfare_seen = 0;
    tour_seen    = 0;
    cmd          = {op, hdg, sq};         // Held until the response.
    cmd_rdy      = 1'b1;
    wait_for_event(1'b0, "clr_cmd_rdy");
    cmd_rdy = 1'b0;
    if (op == TOUR)
      repeat (3) step();                  // Tour has no response.
    else
      wait_for_event(1'b1, "send_resp");
    step();
    check_value("clr_cmd_rdy count", 16'd1, 16'(accept_seen));
    check_value("send_resp count", (op == TOUR) ? 16'd0 : 16'd1, 16'(resp_seen));
    check_value("fanfare_go count", (op == FANFARE) ? 16'd1 : 16'd0, 16'(fanfare_seen));
    check_value("tour_go count", (op == TOUR) ? 16'd1 : 16'd0, 16'(tour_seen));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output checks at the falling edge
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    check_value("clr_cmd_rdy", 16'(exp_accept), 16'(clr_cmd_rdy));
    check_value("tour_go", 16'(exp_tour_go), 16'(tour_go));
    check_value("strt_cal", 16'(exp_strt_cal), 16'(strt_cal));
    check_value("send_resp", 16'(exp_resp), 16'(send_resp));
    check_value("fanfare_go", 16'(exp_fanfare), 16'(fanfare_go));
    check_value("moving", 16'(exp_moving), 16'(moving));
    check_value("frwrd", 16'(exp_frwrd), 16'(frwrd));
    check_value("error", 16'(exp_error), 16'(error));
    if (clr_cmd_rdy)
      accept_seen++;
    if (send_resp)
      resp_seen++;
    if (tour_go)
      tour_seen++;
    if (fanfare_go) begin
      assert (resp_seen == 0) else fail_now("fanfare_go came after send_resp");
      fanfare_seen++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int unsigned seed;
    op_t         op;
    logic [7:0]  hdg;
    logic [3:0]  sq;
    seed = 32'h92e7_c646;
    void'($urandom(seed));
    rst_n        = 1'b0;                  // Held for 5 cycles.
    cmd          = '0;
    cmd_rdy      = 1'b0;
    cal_done     = 1'b0;
    heading      = '0;
    heading_rdy  = 1'b0;
    lftIR        = 1'b0;
    cntrIR       = 1'b0;
    rghtIR       = 1'b0;
    accept_seen  = 0;
    resp_seen    = 0;
    fanfare_seen = 0;
    tour_seen    = 0;
    rdy_wait     = 0;
    ir_wait      = 1;
    cal_wait     = 0;
    turn_cycles  = 0;
    repeat (5) @(posedge clk);
    #5;
    rst_n = 1'b1;
    repeat (2) step();
    for (int i = 0; i < NUM_CMDS; i++) begin
      case ($urandom % 4)
        0:       op = CAL;
        1:       op = TOUR;
        2:       op = MOV;
        default: op = FANFARE;
      endcase
      hdg = 8'($urandom);
      sq  = 4'(1 + $urandom % 4);         // One to four squares.
      run_command(op, hdg, sq);
      repeat ($urandom % 3) step();
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule : cmd_proc_tb

`default_nettype wire

/* files.f */
hdl/knight_pkg.sv
hdl/move_ctrl_if.sv
hdl/cmd_sequencer.sv
hdl/heading_error.sv
hdl/speed_ramp.sv
hdl/square_counter.sv
hdl/cmd_proc.sv
tests/knight_model.sv
tests/cmd_proc_tb.sv

/* Bender.yml */
package:
  name: knight_cmd_proc

sources:
  - hdl/knight_pkg.sv
  - hdl/move_ctrl_if.sv
  - hdl/cmd_sequencer.sv
  - hdl/heading_error.sv
  - hdl/speed_ramp.sv
  - hdl/square_counter.sv
  - hdl/cmd_proc.sv
  - target: test
    files:
      - tests/knight_model.sv
      - tests/cmd_proc_tb.sv
